// ==== tests/mcpu_mem_stimulus.txt ====
# paddr0 we0 v0 dout0 paddr1 we1 v1 dout1 meminput exp_in0 exp_in1 exp_memout latency
# All fields hex, word addresses, bit 29 of the address selects I/O
# RAM writes, full and partial bytes, then parallel reads
00000010 f 1 11223344 00000020 f 1 aabbccdd 00000000 00000000 00000000 00000000 1
00000010 3 1 00005566 00000020 c 1 eeff0000 00000000 00000000 00000000 00000000 1
00000020 0 1 00000000 00000010 0 1 00000000 00000000 eeffccdd 11225566 00000000 1
# Read-first on a shared word, then lane b bytes on top
00000010 0 1 00000000 00000010 f 1 99999999 00000000 11225566 00000000 00000000 1
00000000 0 0 00000000 00000010 0 1 00000000 00000000 00000000 99999999 00000000 1
00000030 f 1 12345678 00000030 6 1 abcdef01 00000000 00000000 00000000 00000000 1
00000030 0 1 00000000 00000000 0 0 00000000 00000000 12cdef78 00000000 00000000 1
# Output register, input port, unmapped offsets
20000000 f 1 a5a5a5a5 00000000 0 0 00000000 00000000 00000000 00000000 a5a5a5a5 1
20000000 2 1 00003c00 00000000 0 0 00000000 00000000 00000000 00000000 a5a53ca5 1
00000000 0 0 00000000 20000001 0 1 00000000 cafef00d 00000000 cafef00d a5a53ca5 1
20000005 0 1 00000000 00000000 0 0 00000000 cafef00d 00000000 00000000 a5a53ca5 1
20000003 f 1 ffffffff 20000001 f 1 ffffffff 00000000 00000000 00000000 a5a53ca5 2
# Two I/O lanes share the bus over two cycles
20000000 0 1 00000000 20000001 0 1 00000000 0badbeef a5a53ca5 0badbeef a5a53ca5 2
20000000 1 1 00000011 20000000 0 1 00000000 00000000 00000000 a5a53c11 a5a53c11 2
# One I/O lane with one RAM lane
20000000 0 1 00000000 00000030 0 1 00000000 00000000 a5a53c11 12cdef78 a5a53c11 1
00000040 f 1 76543210 20000001 0 1 00000000 13579bdf 00000000 13579bdf a5a53c11 1
00000040 0 1 00000000 00000010 0 1 00000000 00000000 76543210 99999999 a5a53c11 1

// ==== flist.f ====
logic/mcpu_mem_pkg.sv
logic/mcpu_dl1c_ram.sv
logic/mcpu_dl1c_arb.sv
logic/mcpu_soc_mmio.sv
logic/mcpu_mem_top.sv
tests/mcpu_mem_assertions.sv
tests/tb_mcpu_mem_top.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module tb_mcpu_mem_top -f flist.f -o sim_tb

run: build
	rm -f $(LOG)
	./obj_dir/sim_tb | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

lint:
	verilator --lint-only --timing --assert --top-module tb_mcpu_mem_top -f flist.f
	verilator --lint-only --top-module mcpu_mem_top logic/mcpu_mem_pkg.sv \
		logic/mcpu_dl1c_ram.sv logic/mcpu_dl1c_arb.sv logic/mcpu_soc_mmio.sv \
		logic/mcpu_mem_top.sv

clean:
	rm -rf obj_dir $(LOG)

// ==== tests/tb_mcpu_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mcpu_mem_top;
  import mcpu_mem_pkg::*;

  localparam int ncols = 13; // Fields per stimulus line

  logic                clkrst_core_clk;
  logic                rst;
  logic [paddr_w-1:0]  mem2dc_paddr0, mem2dc_paddr1;
  logic [be_w-1:0]     mem2dc_write0, mem2dc_write1;
  logic                mem2dc_valid0, mem2dc_valid1;
  logic [data_w-1:0]   mem2dc_data_out0, mem2dc_data_out1;
  logic [data_w-1:0]   mem2dc_data_in0, mem2dc_data_in1;
  logic                dl1c_ready;
  logic [data_w-1:0]   meminput, memoutput;

  logic [31:0] vals[$]; // All fields, row after row
  int          n_rows;
  int          cycle_cnt = 0;
  int          cycle_limit = 0; // Zero until the file is loaded

  mcpu_mem_top DUT (.*);

  initial clkrst_core_clk = 1'b0;
  always #4 clkrst_core_clk = ~clkrst_core_clk; // 8 ns period

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "Run stopped after an error");
  endtask

  task automatic compare_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    assert (actual === expected) else begin
      stop_on_error($sformatf("FAIL %s expected %h got %h", name, expected, actual));
    end
  endtask

  // Runaway guard
  always @(posedge clkrst_core_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      stop_on_error($sformatf("Timeout, stimulus not finished after %0d cycles", cycle_cnt));
    end
  end

  task automatic load_stimulus();
    int          fd;
    int          rc;
    int          n;
    string       line;
    logic [31:0] c [ncols];
    fd = $fopen("tests/mcpu_mem_stimulus.txt", "r");
    if (fd == 0) begin
      stop_on_error("Cannot open tests/mcpu_mem_stimulus.txt");
    end
    while (!$feof(fd)) begin
      rc = $fgets(line, fd);
      if (rc > 0 && line[0] != "#") begin // Hash lines are notes
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", c[0], c[1], c[2],
                    c[3], c[4], c[5], c[6], c[7], c[8], c[9], c[10], c[11], c[12]);
        if (n == ncols) begin
          foreach (c[i]) begin
            vals.push_back(c[i]);
          end
        end else if (n > 0) begin
          stop_on_error($sformatf("Stimulus line has %0d fields instead of 13", n));
        end
      end
    end
    $fclose(fd);
  endtask

  initial begin
    int base;
    int lat;
    rst = 1'b1;
    mem2dc_paddr0 = '0;
    mem2dc_write0 = '0;
    mem2dc_valid0 = 1'b0;
    mem2dc_data_out0 = '0;
    mem2dc_paddr1 = '0;
    mem2dc_write1 = '0;
    mem2dc_valid1 = 1'b0;
    mem2dc_data_out1 = '0;
    meminput = '0;
    load_stimulus();
    n_rows = vals.size() / ncols;
    if (n_rows == 0) begin
      stop_on_error("Stimulus file holds no transactions");
    end
    cycle_limit = n_rows * 4 + 20;
    repeat (2) @(posedge clkrst_core_clk);
    rst <= 1'b0;
    @(negedge clkrst_core_clk);
    compare_word("memoutput", 32'h0, memoutput); // Cleared by reset
    for (int r = 0; r < n_rows; r++) begin
      base = r * ncols;
      @(posedge clkrst_core_clk); // Edge that ends the previous done
      mem2dc_paddr0 <= vals[base][paddr_w-1:0];
      mem2dc_write0 <= vals[base + 1][be_w-1:0];
      mem2dc_valid0 <= vals[base + 2][0];
      mem2dc_data_out0 <= vals[base + 3];
      mem2dc_paddr1 <= vals[base + 4][paddr_w-1:0];
      mem2dc_write1 <= vals[base + 5][be_w-1:0];
      mem2dc_valid1 <= vals[base + 6][0];
      mem2dc_data_out1 <= vals[base + 7];
      meminput <= vals[base + 8];
      lat = 0;
      do begin
        @(posedge clkrst_core_clk);
        lat++; // Edges since acceptance
        @(negedge clkrst_core_clk); // Outputs settled
      end while (!dl1c_ready);
      compare_word("mem2dc_data_in0", vals[base + 9], mem2dc_data_in0);
      compare_word("mem2dc_data_in1", vals[base + 10], mem2dc_data_in1);
      compare_word("memoutput", vals[base + 11], memoutput);
      compare_word("dl1c_ready latency", vals[base + 12], lat);
    end
    @(posedge clkrst_core_clk);
    mem2dc_valid0 <= 1'b0;
    mem2dc_valid1 <= 1'b0;
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/mcpu_mem_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcpu_mem_assertions (
  input wire                               clkrst_core_clk,
  input wire                               rst,
  input wire                               dl1c_ready,
  input wire                               periph_re,
  input wire [mcpu_mem_pkg::be_w-1:0]      periph_we
);

  // Done is a one-cycle pulse
  ready_pulse: assert property (@(posedge clkrst_core_clk) disable iff (rst)
    dl1c_ready |=> !dl1c_ready)
    else $error("dl1c_ready high on two consecutive cycles");

  // Bus is quiet while the core collects the result
  quiet_bus: assert property (@(posedge clkrst_core_clk) disable iff (rst)
    dl1c_ready |-> (!periph_re && periph_we == '0))
    else $error("peripheral strobe during a respond cycle");

  // Read and write never share a slot
  one_strobe: assert property (@(posedge clkrst_core_clk) disable iff (rst)
    !(periph_re && |periph_we))
    else $error("periph_re and periph_we active together");

  no_early_ready: assert property (@(posedge clkrst_core_clk)
    $fell(rst) |-> !dl1c_ready) // First cycle out of reset
    else $error("dl1c_ready high right after reset release");

endmodule

bind mcpu_dl1c_arb mcpu_mem_assertions arb_checks (
  .clkrst_core_clk (clkrst_core_clk),
  .rst             (rst),
  .dl1c_ready      (dl1c_ready),
  .periph_re       (periph_re),
  .periph_we       (periph_we)
);

`default_nettype wire

// ==== logic/mcpu_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcpu_mem_top (
  input  wire                                  clkrst_core_clk,
  input  wire                                  rst,
  input  wire  [mcpu_mem_pkg::paddr_w-1:0]     mem2dc_paddr0,
  input  wire  [mcpu_mem_pkg::be_w-1:0]        mem2dc_write0,
  input  wire                                  mem2dc_valid0,
  input  wire  [mcpu_mem_pkg::data_w-1:0]      mem2dc_data_out0,
  input  wire  [mcpu_mem_pkg::paddr_w-1:0]     mem2dc_paddr1,
  input  wire  [mcpu_mem_pkg::be_w-1:0]        mem2dc_write1,
  input  wire                                  mem2dc_valid1,
  input  wire  [mcpu_mem_pkg::data_w-1:0]      mem2dc_data_out1,
  output logic [mcpu_mem_pkg::data_w-1:0]      mem2dc_data_in0,
  output logic [mcpu_mem_pkg::data_w-1:0]      mem2dc_data_in1,
  output logic                                 dl1c_ready,
  input  wire  [mcpu_mem_pkg::data_w-1:0]      meminput,
  output logic [mcpu_mem_pkg::data_w-1:0]      memoutput
);
  import mcpu_mem_pkg::*;

  // Arbiter to RAM
  logic              ram_re_a, ram_re_b;
  logic [be_w-1:0]   ram_we_a, ram_we_b;
  logic [ram_aw-1:0] ram_addr_a, ram_addr_b;
  logic [data_w-1:0] ram_wdata_a, ram_wdata_b;
  logic [data_w-1:0] ram_rdata_a, ram_rdata_b;

  // Arbiter to I/O block
  logic                periph_re;
  logic [be_w-1:0]     periph_we;
  logic [io_off_w-1:0] periph_addr;
  logic [data_w-1:0]   periph_wdata, periph_rdata;

  mcpu_dl1c_arb arb (
    .clkrst_core_clk  (clkrst_core_clk),
    .rst              (rst),
    .mem2dc_paddr0    (mem2dc_paddr0),
    .mem2dc_write0    (mem2dc_write0),
    .mem2dc_valid0    (mem2dc_valid0),
    .mem2dc_data_out0 (mem2dc_data_out0),
    .mem2dc_paddr1    (mem2dc_paddr1),
    .mem2dc_write1    (mem2dc_write1),
    .mem2dc_valid1    (mem2dc_valid1),
    .mem2dc_data_out1 (mem2dc_data_out1),
    .mem2dc_data_in0  (mem2dc_data_in0),
    .mem2dc_data_in1  (mem2dc_data_in1),
    .dl1c_ready       (dl1c_ready), // Shared done for both lanes
    .ram_re_a         (ram_re_a),
    .ram_we_a         (ram_we_a),
    .ram_addr_a       (ram_addr_a),
    .ram_wdata_a      (ram_wdata_a),
    .ram_rdata_a      (ram_rdata_a),
    .ram_re_b         (ram_re_b),
    .ram_we_b         (ram_we_b),
    .ram_addr_b       (ram_addr_b),
    .ram_wdata_b      (ram_wdata_b),
    .ram_rdata_b      (ram_rdata_b),
    .periph_re        (periph_re),
    .periph_we        (periph_we),
    .periph_addr      (periph_addr),
    .periph_wdata     (periph_wdata),
    .periph_rdata     (periph_rdata)
  );

  mcpu_dl1c_ram ram (
    .clkrst_core_clk (clkrst_core_clk),
    .ram_re_a        (ram_re_a),
    .ram_we_a        (ram_we_a),
    .ram_addr_a      (ram_addr_a),
    .ram_wdata_a     (ram_wdata_a),
    .ram_rdata_a     (ram_rdata_a),
    .ram_re_b        (ram_re_b),
    .ram_we_b        (ram_we_b),
    .ram_addr_b      (ram_addr_b),
    .ram_wdata_b     (ram_wdata_b),
    .ram_rdata_b     (ram_rdata_b)
  );

  mcpu_soc_mmio mmio (
    .clkrst_core_clk (clkrst_core_clk),
    .rst             (rst),
    .periph_re       (periph_re),
    .periph_we       (periph_we),
    .periph_addr     (periph_addr),
    .periph_wdata    (periph_wdata),
    .periph_rdata    (periph_rdata),
    .meminput        (meminput), // Board input pins
    .memoutput       (memoutput) // Board output pins
  );

endmodule

`default_nettype wire

// ==== logic/mcpu_soc_mmio.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcpu_soc_mmio (
  input  wire                                  clkrst_core_clk,
  input  wire                                  rst,
  input  wire                                  periph_re,
  input  wire  [mcpu_mem_pkg::be_w-1:0]        periph_we,
  input  wire  [mcpu_mem_pkg::io_off_w-1:0]    periph_addr,
  input  wire  [mcpu_mem_pkg::data_w-1:0]      periph_wdata,
  output logic [mcpu_mem_pkg::data_w-1:0]      periph_rdata,
  input  wire  [mcpu_mem_pkg::data_w-1:0]      meminput,
  output logic [mcpu_mem_pkg::data_w-1:0]      memoutput
);
  import mcpu_mem_pkg::*;

  logic out_sel; // Write hits the output register

  assign out_sel = (periph_addr == io_memout);

  // Output register, byte writable
  always_ff @(posedge clkrst_core_clk) begin
    if (rst) begin
      memoutput <= '0;
    end else if (out_sel) begin
      for (int i = 0; i < be_w; i++) begin
        if (periph_we[i]) begin
          memoutput[8*i +: 8] <= periph_wdata[8*i +: 8];
        end
      end
    end
  end

  // Registered read data
  always_ff @(posedge clkrst_core_clk) begin
    if (periph_re) begin
      case (periph_addr)
        io_memout: periph_rdata <= memoutput;
        io_memin:  periph_rdata <= meminput; // Sampled at the strobe edge
        default:   periph_rdata <= '0; // Unmapped
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/mcpu_dl1c_arb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcpu_dl1c_arb (
  input  wire                                  clkrst_core_clk,
  input  wire                                  rst,
  // Core lane 0
  input  wire  [mcpu_mem_pkg::paddr_w-1:0]     mem2dc_paddr0,
  input  wire  [mcpu_mem_pkg::be_w-1:0]        mem2dc_write0,
  input  wire                                  mem2dc_valid0,
  input  wire  [mcpu_mem_pkg::data_w-1:0]      mem2dc_data_out0,
  // Core lane 1
  input  wire  [mcpu_mem_pkg::paddr_w-1:0]     mem2dc_paddr1,
  input  wire  [mcpu_mem_pkg::be_w-1:0]        mem2dc_write1,
  input  wire                                  mem2dc_valid1,
  input  wire  [mcpu_mem_pkg::data_w-1:0]      mem2dc_data_out1,
  // Return to core
  output logic [mcpu_mem_pkg::data_w-1:0]      mem2dc_data_in0,
  output logic [mcpu_mem_pkg::data_w-1:0]      mem2dc_data_in1,
  output logic                                 dl1c_ready,
  // RAM ports
  output logic                                 ram_re_a,
  output logic [mcpu_mem_pkg::be_w-1:0]        ram_we_a,
  output logic [mcpu_mem_pkg::ram_aw-1:0]      ram_addr_a,
  output logic [mcpu_mem_pkg::data_w-1:0]      ram_wdata_a,
  input  wire  [mcpu_mem_pkg::data_w-1:0]      ram_rdata_a,
  output logic                                 ram_re_b,
  output logic [mcpu_mem_pkg::be_w-1:0]        ram_we_b,
  output logic [mcpu_mem_pkg::ram_aw-1:0]      ram_addr_b,
  output logic [mcpu_mem_pkg::data_w-1:0]      ram_wdata_b,
  input  wire  [mcpu_mem_pkg::data_w-1:0]      ram_rdata_b,
  // Peripheral bus
  output logic                                 periph_re,
  output logic [mcpu_mem_pkg::be_w-1:0]        periph_we,
  output logic [mcpu_mem_pkg::io_off_w-1:0]    periph_addr,
  output logic [mcpu_mem_pkg::data_w-1:0]      periph_wdata,
  input  wire  [mcpu_mem_pkg::data_w-1:0]      periph_rdata
);
  import mcpu_mem_pkg::*;

  typedef enum logic [1:0] {st_idle, st_slot2, st_resp} state_t;

  state_t            state;
  logic              idle, accept;
  logic              rd0, rd1, io0, io1, ram0, ram1; // Lane decode
  logic              sel_b, p_act; // Peripheral bus owner
  logic [be_w-1:0]   p_we;
  logic              rd_ram_a, rd_ram_b, rd_io_a, rd_io_b, io_pair; // Captured at accept
  logic [data_w-1:0] io_a_hold; // Lane a I/O data across slot 2

  assign idle = (state == st_idle);
  assign rd0 = ~|mem2dc_write0; // No enables is a read
  assign rd1 = ~|mem2dc_write1;
  assign io0 = mem2dc_valid0 & mem2dc_paddr0[io_bit];
  assign io1 = mem2dc_valid1 & mem2dc_paddr1[io_bit];
  assign ram0 = mem2dc_valid0 & ~mem2dc_paddr0[io_bit];
  assign ram1 = mem2dc_valid1 & ~mem2dc_paddr1[io_bit];
  assign accept = idle & (mem2dc_valid0 | mem2dc_valid1); // Valids ignored outside idle

  // RAM strobes only in the accept cycle
  assign ram_re_a = idle & ram0 & rd0;
  assign ram_we_a = (idle & ram0) ? mem2dc_write0 : '0;
  assign ram_addr_a = mem2dc_paddr0[ram_aw-1:0];
  assign ram_wdata_a = mem2dc_data_out0;
  assign ram_re_b = idle & ram1 & rd1;
  assign ram_we_b = (idle & ram1) ? mem2dc_write1 : '0;
  assign ram_addr_b = mem2dc_paddr1[ram_aw-1:0];
  assign ram_wdata_b = mem2dc_data_out1;

  // Lane a owns the bus first, lane b in slot 2 or when alone
  assign sel_b = (state == st_slot2) | (idle & io1 & ~io0);
  assign p_act = (state == st_slot2) | (idle & (io0 | io1));
  assign p_we = sel_b ? mem2dc_write1 : mem2dc_write0;
  assign periph_re = p_act & ~|p_we;
  assign periph_we = p_act ? p_we : '0;
  assign periph_addr = sel_b ? mem2dc_paddr1[io_off_w-1:0] : mem2dc_paddr0[io_off_w-1:0];
  assign periph_wdata = sel_b ? mem2dc_data_out1 : mem2dc_data_out0;

  always_ff @(posedge clkrst_core_clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (accept) begin
            state <= (io0 & io1) ? st_slot2 : st_resp; // Two I/O lanes need two slots
          end
        end
        st_slot2: state <= st_resp;
        default: state <= st_idle; // Respond lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clkrst_core_clk) begin
    if (accept) begin
      rd_ram_a <= ram0 & rd0;
      rd_ram_b <= ram1 & rd1;
      rd_io_a <= io0 & rd0;
      rd_io_b <= io1 & rd1;
      io_pair <= io0 & io1;
    end
    if (state == st_slot2) begin
      io_a_hold <= periph_rdata; // Bus result of lane a
    end
  end

  assign dl1c_ready = (state == st_resp);

  // Zero for writes and idle lanes
  always_comb begin
    mem2dc_data_in0 = '0;
    mem2dc_data_in1 = '0;
    if (dl1c_ready) begin
      if (rd_ram_a) begin
        mem2dc_data_in0 = ram_rdata_a;
      end else if (rd_io_a) begin
        mem2dc_data_in0 = io_pair ? io_a_hold : periph_rdata;
      end
      if (rd_ram_b) begin
        mem2dc_data_in1 = ram_rdata_b;
      end else if (rd_io_b) begin
        mem2dc_data_in1 = periph_rdata; // Lane b always last on the bus
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/mcpu_dl1c_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcpu_dl1c_ram (
  input  wire                                  clkrst_core_clk,
  // Port a
  input  wire                                  ram_re_a,
  input  wire  [mcpu_mem_pkg::be_w-1:0]        ram_we_a,
  input  wire  [mcpu_mem_pkg::ram_aw-1:0]      ram_addr_a,
  input  wire  [mcpu_mem_pkg::data_w-1:0]      ram_wdata_a,
  output logic [mcpu_mem_pkg::data_w-1:0]      ram_rdata_a,
  // Port b
  input  wire                                  ram_re_b,
  input  wire  [mcpu_mem_pkg::be_w-1:0]        ram_we_b,
  input  wire  [mcpu_mem_pkg::ram_aw-1:0]      ram_addr_b,
  input  wire  [mcpu_mem_pkg::data_w-1:0]      ram_wdata_b,
  output logic [mcpu_mem_pkg::data_w-1:0]      ram_rdata_b
);
  import mcpu_mem_pkg::*;

  logic [data_w-1:0] mem [ram_words]; // Word array

  // Reads and writes share one process so that port b's bytes win
  always_ff @(posedge clkrst_core_clk) begin
    if (ram_re_a) begin
      ram_rdata_a <= mem[ram_addr_a]; // Old word, read-first
    end
    if (ram_re_b) begin
      ram_rdata_b <= mem[ram_addr_b]; // Holds when not reading
    end
    for (int i = 0; i < be_w; i++) begin
      if (ram_we_a[i]) begin
        mem[ram_addr_a][8*i +: 8] <= ram_wdata_a[8*i +: 8]; // Byte lane i
      end
    end
    for (int i = 0; i < be_w; i++) begin
      if (ram_we_b[i]) begin
        mem[ram_addr_b][8*i +: 8] <= ram_wdata_b[8*i +: 8]; // Later NBA, lands on top
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/mcpu_mem_pkg.sv ====
`default_nettype none

package mcpu_mem_pkg;

  // Lane word address, byte address bits 31:2
  localparam int unsigned paddr_w = 30;
  localparam int unsigned data_w = 32; // Data word
  localparam int unsigned be_w = 4; // One enable per byte

  // Address bit 29 set means I/O window, clear means RAM
  localparam int unsigned io_bit = 29;

  localparam int unsigned ram_words = 256; // RAM depth in words
  localparam int unsigned ram_aw = 8; // Low word-address bits index the RAM

  localparam int unsigned io_off_w = 4; // I/O register offset width

  // I/O register offsets
  localparam logic [io_off_w-1:0] io_memout = 4'd0; // Output register, read/write
  localparam logic [io_off_w-1:0] io_memin = 4'd1; // Input port, read only

endpackage

`default_nettype wire
